//--- build.f
+incdir+hw
hw/bp_pkg.sv
hw/fold_history.sv
hw/history_control.sv
hw/tage_bank.sv
hw/tage_provider_select.sv
hw/branch_predictor_top.sv
tb/tb_branch_predictor.sv

//--- hw/bp_cfg.svh
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// global history buffer
`define GHIST_SIZE          64
`define GHIST_WIDTH         6
`define SLOT_NUM            2

// tage geometry
`define TAGE_BANK           4
`define TAGE_BANK_WIDTH     2
`define TAGE_SET_WIDTH      6   // 64 sets per bank
`define TAGE_TAG_COMPRESS1  8
`define TAGE_TAG_COMPRESS2  7
`define TAGE_TAG_WIDTH      8
`define TAGE_CTR_WIDTH      3

// bank i uses bits [i*16 +: 16]
`define TAGE_HIST_LENGTH    {16'd32, 16'd16, 16'd8, 16'd4}

`define PC_WIDTH            32

// downstream queue
`define FTQ_CREDITS         4
`define FTQ_CREDIT_WIDTH    3

`define PROVIDER_WIDTH      3
`define PROVIDER_NONE       3'd7

`endif

//--- hw/bp_pkg.sv
`include "bp_cfg.svh"

package bp_pkg;

    // folded copies of the global history, one set per bank
    typedef struct packed {
        logic [`TAGE_BANK-1:0][`TAGE_SET_WIDTH-1:0]     fold_idx;
        logic [`TAGE_BANK-1:0][`TAGE_TAG_COMPRESS1-1:0] fold_tag1;
        logic [`TAGE_BANK-1:0][`TAGE_TAG_COMPRESS2-1:0] fold_tag2;
    } fold_hist_t;

    typedef struct packed {
        logic [`GHIST_WIDTH-1:0] ghist_idx;
        fold_hist_t              tage_history;
    } branch_history_t;

    // snapshot a block was predicted from
    typedef struct packed {
        logic [`GHIST_WIDTH-1:0] ghist_idx;
        fold_hist_t              tage_history;
    } redirect_info_t;

    typedef struct packed {
        logic           en;
        logic [1:0]     cond_num;      // 0 to SLOT_NUM
        logic           taken;
        logic           s2_redirect;
        redirect_info_t redirect_info;
    } pred_result_t;

    typedef struct packed {
        logic [1:0]                  cond_num;
        logic                        taken;
        redirect_info_t              redirect_info;
        logic [`PC_WIDTH-1:0]        pc;
        logic [`TAGE_BANK_WIDTH-1:0] train_bank;
        logic                        train_taken;
    } squash_info_t;

    typedef struct packed {
        logic                       hit;
        logic                       taken;
        logic [`TAGE_CTR_WIDTH-1:0] ctr;
    } bank_resp_t;

    typedef struct packed {
        logic [`PC_WIDTH-1:0]       pc;
        logic                       taken;
        logic [`PROVIDER_WIDTH-1:0] provider;   // PROVIDER_NONE on miss
        logic [`GHIST_WIDTH-1:0]    ghist_idx;
    } pred_out_t;

    // source of the next history position
    typedef enum logic [1:0] {
        HIST_HOLD,
        HIST_PRED,
        HIST_REDIRECT,
        HIST_SQUASH
    } hist_src_e;

    typedef enum logic [1:0] {
        CTR_INC,
        CTR_DEC,
        CTR_ALLOC,
        CTR_NONE
    } ctr_op_e;

endpackage

//--- hw/branch_predictor_top.sv
`include "bp_cfg.svh"

module branch_predictor_top import bp_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  pred_result_t         result,
    input  logic                 squash,
    input  squash_info_t         squash_info,
    input  logic                 req_valid,
    input  logic [`PC_WIDTH-1:0] req_pc,
    input  logic                 credit_return,
    output logic                 req_ready,
    output logic                 pred_valid,
    output pred_out_t            pred,
    output branch_history_t      history
);
    localparam logic [`TAGE_BANK*16-1:0] hist_lengths = `TAGE_HIST_LENGTH;

    logic                        bank_req_valid;
    bank_resp_t [`TAGE_BANK-1:0] bank_resp;

    assign bank_req_valid = req_valid & req_ready;   // no lookup without a credit

    history_control u_history (
        .clk        (clk),
        .rst        (rst),
        .result     (result),
        .squash     (squash),
        .squash_info(squash_info),
        .history    (history)
    );

    for (genvar b = 0; b < `TAGE_BANK; b++) begin : g_bank
        logic train_en;
        assign train_en = squash & (squash_info.train_bank == `TAGE_BANK_WIDTH'(b));

        tage_bank #(
            .hist_len(int'(hist_lengths[b*16 +: 16]))
        ) u_bank (
            .clk        (clk),
            .rst        (rst),
            .req_valid  (bank_req_valid),
            .req_pc     (req_pc),
            .history    (history),
            .train_en   (train_en),
            .train_pc   (squash_info.pc),
            .train_fold (squash_info.redirect_info.tage_history),
            .train_taken(squash_info.train_taken),
            .resp       (bank_resp[b])
        );
    end

    tage_provider_select u_select (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (bank_req_valid),
        .req_pc       (req_pc),
        .history      (history),
        .bank_resp    (bank_resp),
        .credit_return(credit_return),
        .req_ready    (req_ready),
        .pred_valid   (pred_valid),
        .pred         (pred)
    );

endmodule

//--- hw/fold_history.sv
`include "bp_cfg.svh"

module fold_history #(
    parameter int compress_len = 8,
    parameter int origin_len   = 16
) (
    input  logic [compress_len-1:0] origin,
    input  logic [1:0]              cond_num,
    input  logic                    dir,
    input  logic [`SLOT_NUM-1:0]    reverse_dir,  // [0] oldest bit leaving the window
    output logic [compress_len-1:0] folded
);
    localparam int out_pos0 = origin_len % compress_len;
    localparam int out_pos1 = (origin_len + 1) % compress_len;

    logic [compress_len-1:0] shift1;
    logic [compress_len-1:0] shift2;
    logic [compress_len-1:0] drop1;
    logic [compress_len-1:0] drop2;

    if (origin_len < compress_len) begin : g_short
        assign shift1 = origin << 1;    // upper bits are always zero here
        assign shift2 = origin << 2;
    end else begin : g_wrap
        assign shift1 = {origin[compress_len-2:0], origin[compress_len-1]};
        assign shift2 = {origin[compress_len-3:0], origin[compress_len-1 -: 2]};
    end

    always_comb begin
        drop1           = '0;
        drop1[out_pos0] = reverse_dir[0];
        drop2           = '0;
        drop2[out_pos0] = reverse_dir[1];
        drop2[out_pos1] = reverse_dir[0];
        case (cond_num)
            2'd1:    folded = shift1 ^ drop1 ^ compress_len'(dir);
            2'd2:    folded = shift2 ^ drop2 ^ compress_len'(dir);
            default: folded = origin;
        endcase
    end

endmodule

//--- hw/history_control.sv
`include "bp_cfg.svh"

module history_control import bp_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  pred_result_t    result,
    input  logic            squash,
    input  squash_info_t    squash_info,
    output branch_history_t history
);
    localparam logic [`TAGE_BANK*16-1:0] hist_lengths = `TAGE_HIST_LENGTH;

    logic [`GHIST_SIZE-1:0]                 ghist;
    logic [`GHIST_WIDTH-1:0]                pos;
    fold_hist_t                             folds;
    hist_src_e                              src;
    logic [`GHIST_WIDTH-1:0]                base_idx;
    fold_hist_t                             base_folds;
    fold_hist_t                             next_folds;
    logic [1:0]                             cond_num;
    logic                                   taken;
    logic [`SLOT_NUM-1:0]                   ghist_we;
    logic [`SLOT_NUM-1:0]                   push_bit;
    logic [`SLOT_NUM-1:0][`GHIST_WIDTH-1:0] wr_idx;

    assign history = '{ghist_idx: pos, tage_history: folds};

    // squash over redirect over plain advance
    always_comb begin
        if (squash) begin
            src = HIST_SQUASH;
        end else if (result.s2_redirect) begin
            src = HIST_REDIRECT;
        end else if (result.en) begin
            src = HIST_PRED;
        end else begin
            src = HIST_HOLD;
        end
    end

    always_comb begin
        base_idx   = pos;
        base_folds = folds;
        cond_num   = 2'd0;
        taken      = 1'b0;
        case (src)
            HIST_SQUASH: begin
                base_idx   = squash_info.redirect_info.ghist_idx;
                base_folds = squash_info.redirect_info.tage_history;
                cond_num   = squash_info.cond_num;
                taken      = squash_info.taken;
            end
            HIST_REDIRECT: begin
                base_idx   = result.redirect_info.ghist_idx;
                base_folds = result.redirect_info.tage_history;
                cond_num   = result.cond_num;
                taken      = result.taken;
            end
            HIST_PRED: begin
                cond_num = result.cond_num;
                taken    = result.taken;
            end
            default: ;
        endcase
    end

    // only the last pushed bit carries the taken flag
    for (genvar j = 0; j < `SLOT_NUM; j++) begin : g_slot
        assign wr_idx[j]   = base_idx + `GHIST_WIDTH'(j);
        assign ghist_we[j] = cond_num > 2'(j);
        assign push_bit[j] = (cond_num == 2'(j + 1)) & taken;
    end

    // ------------------------------------------------------------------------
    // per-bank fold update
    // ------------------------------------------------------------------------
    for (genvar b = 0; b < `TAGE_BANK; b++) begin : g_bank
        localparam int hist_len = int'(hist_lengths[b*16 +: 16]);

        logic [`SLOT_NUM-1:0] rev_dir;

        for (genvar j = 0; j < `SLOT_NUM; j++) begin : g_rev
            logic [`GHIST_WIDTH-1:0] rev_idx;
            assign rev_idx    = base_idx - `GHIST_WIDTH'(hist_len) + `GHIST_WIDTH'(j);
            assign rev_dir[j] = ghist[rev_idx];
        end

        fold_history #(
            .compress_len(`TAGE_SET_WIDTH),
            .origin_len  (hist_len)
        ) u_fold_idx (
            .origin     (base_folds.fold_idx[b]),
            .cond_num   (cond_num),
            .dir        (taken),
            .reverse_dir(rev_dir),
            .folded     (next_folds.fold_idx[b])
        );

        fold_history #(
            .compress_len(`TAGE_TAG_COMPRESS1),
            .origin_len  (hist_len)
        ) u_fold_tag1 (
            .origin     (base_folds.fold_tag1[b]),
            .cond_num   (cond_num),
            .dir        (taken),
            .reverse_dir(rev_dir),
            .folded     (next_folds.fold_tag1[b])
        );

        fold_history #(
            .compress_len(`TAGE_TAG_COMPRESS2),
            .origin_len  (hist_len)
        ) u_fold_tag2 (
            .origin     (base_folds.fold_tag2[b]),
            .cond_num   (cond_num),
            .dir        (taken),
            .reverse_dir(rev_dir),
            .folded     (next_folds.fold_tag2[b])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            pos   <= '0;
            folds <= '0;
        end else begin
            if (src != HIST_HOLD) begin
                pos   <= base_idx + `GHIST_WIDTH'(cond_num);
                folds <= next_folds;    // equals base_folds when nothing is pushed
            end
            for (int j = 0; j < `SLOT_NUM; j++) begin
                if (ghist_we[j]) begin
                    ghist[wr_idx[j]] <= push_bit[j];
                end
            end
        end
    end

endmodule

//--- hw/tage_bank.sv
`include "bp_cfg.svh"

module tage_bank import bp_pkg::*; #(
    parameter int hist_len = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  logic [`PC_WIDTH-1:0] req_pc,
    input  branch_history_t      history,
    input  logic                 train_en,
    input  logic [`PC_WIDTH-1:0] train_pc,
    input  fold_hist_t           train_fold,
    input  logic                 train_taken,
    output bank_resp_t           resp
);
    localparam int sets = 1 << `TAGE_SET_WIDTH;

    // bank number recovered from the length table
    function automatic int find_bank(int len);
        logic [`TAGE_BANK*16-1:0] lengths;
        int                       id;
        lengths = `TAGE_HIST_LENGTH;
        id      = 0;
        for (int i = 0; i < `TAGE_BANK; i++) begin
            if (int'(lengths[i*16 +: 16]) == len) begin
                id = i;
            end
        end
        return id;
    endfunction

    localparam int bank_id = find_bank(hist_len);

    function automatic logic [`TAGE_SET_WIDTH-1:0] calc_idx(
        logic [`PC_WIDTH-1:0] pc,
        fold_hist_t           f
    );
        return pc[2 +: `TAGE_SET_WIDTH] ^ f.fold_idx[bank_id];
    endfunction

    function automatic logic [`TAGE_TAG_WIDTH-1:0] calc_tag(
        logic [`PC_WIDTH-1:0] pc,
        fold_hist_t           f
    );
        return pc[2 + `TAGE_SET_WIDTH +: `TAGE_TAG_WIDTH] ^ f.fold_tag1[bank_id]
               ^ {f.fold_tag2[bank_id], 1'b0};
    endfunction

    logic [sets-1:0]            valid;
    logic [`TAGE_TAG_WIDTH-1:0] tag_mem [sets];
    logic [`TAGE_CTR_WIDTH-1:0] ctr_mem [sets];
    logic [`TAGE_SET_WIDTH-1:0] rd_idx;
    logic [`TAGE_TAG_WIDTH-1:0] rd_tag;
    logic [`TAGE_SET_WIDTH-1:0] tr_idx;
    logic [`TAGE_TAG_WIDTH-1:0] tr_tag;
    logic                       tr_match;
    ctr_op_e                    op;

    assign rd_idx   = calc_idx(req_pc, history.tage_history);
    assign rd_tag   = calc_tag(req_pc, history.tage_history);
    assign tr_idx   = calc_idx(train_pc, train_fold);
    assign tr_tag   = calc_tag(train_pc, train_fold);
    assign tr_match = valid[tr_idx] && (tag_mem[tr_idx] == tr_tag);

    always_comb begin
        if (!train_en) begin
            op = CTR_NONE;
        end else if (!tr_match) begin
            op = CTR_ALLOC;
        end else if (train_taken) begin
            op = CTR_INC;
        end else begin
            op = CTR_DEC;
        end
    end

    // ------------------------------------------------------------------------
    // training
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (op == CTR_ALLOC) begin
            valid[tr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        case (op)
            CTR_INC: begin
                if (ctr_mem[tr_idx] != '1) begin
                    ctr_mem[tr_idx] <= ctr_mem[tr_idx] + 1'b1;  // saturating
                end
            end
            CTR_DEC: begin
                if (ctr_mem[tr_idx] != '0) begin
                    ctr_mem[tr_idx] <= ctr_mem[tr_idx] - 1'b1;
                end
            end
            CTR_ALLOC: begin
                tag_mem[tr_idx] <= tr_tag;
                // weak counter toward the outcome
                ctr_mem[tr_idx] <= train_taken ? {1'b1, {(`TAGE_CTR_WIDTH-1){1'b0}}}
                                               : {1'b0, {(`TAGE_CTR_WIDTH-1){1'b1}}};
            end
            default: ;
        endcase
    end

    // registered read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp <= '0;
        end else begin
            resp.hit   <= req_valid && valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
            resp.taken <= ctr_mem[rd_idx][`TAGE_CTR_WIDTH-1];
            resp.ctr   <= ctr_mem[rd_idx];
        end
    end

endmodule

//--- hw/tage_provider_select.sv
`include "bp_cfg.svh"

module tage_provider_select import bp_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid,
    input  logic [`PC_WIDTH-1:0]         req_pc,
    input  branch_history_t              history,
    input  bank_resp_t [`TAGE_BANK-1:0]  bank_resp,
    input  logic                         credit_return,
    output logic                         req_ready,
    output logic                         pred_valid,
    output pred_out_t                    pred
);
    logic [`FTQ_CREDIT_WIDTH-1:0] credits;
    logic                         accept;
    logic                         s1_valid;
    logic [`PC_WIDTH-1:0]         s1_pc;
    logic [`GHIST_WIDTH-1:0]      s1_ghist_idx;
    logic                         sel_hit;
    logic                         sel_taken;
    logic [`PROVIDER_WIDTH-1:0]   sel_bank;

    assign req_ready = credits != '0;
    assign accept    = req_valid & req_ready;

    // ------------------------------------------------------------------------
    // credits, one taken per accepted lookup
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= `FTQ_CREDIT_WIDTH'(`FTQ_CREDITS);
        end else begin
            credits <= credits - `FTQ_CREDIT_WIDTH'(accept)
                               + `FTQ_CREDIT_WIDTH'(credit_return);
        end
    end

    // stage 1 lines up with the bank read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_pc        <= req_pc;
            s1_ghist_idx <= history.ghist_idx;
        end
    end

    // longest history wins
    always_comb begin
        sel_hit   = 1'b0;
        sel_taken = 1'b0;
        sel_bank  = `PROVIDER_NONE;
        for (int b = 0; b < `TAGE_BANK; b++) begin
            if (bank_resp[b].hit) begin
                sel_hit   = 1'b1;
                sel_taken = bank_resp[b].taken;
                sel_bank  = `PROVIDER_WIDTH'(b);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            pred.pc        <= s1_pc;
            pred.taken     <= sel_hit & sel_taken;  // miss means not taken
            pred.provider  <= sel_bank;
            pred.ghist_idx <= s1_ghist_idx;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f build.f --top-module tb_branch_predictor -o sim_bp
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_bp > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0

//--- tb/bp_vectors.txt
// op cond taken back exp_idx aux pc  (1 advance, 2 redirect, 3 squash, 4 lookup, 5 credit,
// 6 squash with redirect, 7 blocked lookup, 0 end; aux is bank*2+train_taken or provider)
1 1 1 0 01 0 00000000
1 2 0 0 03 0 00000000
1 0 1 0 03 0 00000000
1 2 1 0 05 0 00000000
1 2 1 0 07 0 00000000
1 1 0 0 08 0 00000000
3 0 0 0 08 7 00001234
4 0 1 0 00 3 00001234
4 0 0 0 00 7 00002238
5 2 1 0 00 0 00000000
4 0 0 0 00 7 00000040
4 0 0 0 00 7 00000044
4 0 0 0 00 7 00000048
4 0 0 0 00 7 0000004c
7 0 0 0 00 0 00000050
5 1 1 0 00 0 00000000
4 0 0 0 00 7 00000050
7 0 0 0 00 0 00000054
5 4 1 0 00 0 00000000
2 2 1 3 07 0 00000000
3 1 0 2 06 0 00000100
6 2 1 1 07 3 00000200
2 0 0 9 3e 0 00000000
1 2 1 0 00 0 00000000
1 1 1 0 01 0 00000000
2 2 0 3 00 0 00000000
1 2 0 0 02 0 00000000
0 0 0 0 00 0 00000000

//--- tb/tb_branch_predictor.sv
`include "bp_cfg.svh"

module tb_branch_predictor import bp_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period    = 8;
    localparam int vec_fields    = 7;
    localparam int max_vecs      = 64;
    localparam int rand_count    = 200;
    localparam logic [`TAGE_BANK*16-1:0] hist_lengths = `TAGE_HIST_LENGTH;

    logic                 clk;
    logic                 rst;
    pred_result_t         result;
    logic                 squash;
    squash_info_t         squash_info;
    logic                 req_valid;
    logic [`PC_WIDTH-1:0] req_pc;
    logic                 credit_return;
    logic                 req_ready;
    logic                 pred_valid;
    pred_out_t            pred;
    branch_history_t      history;

    logic [31:0]            vec_mem [0:vec_fields*max_vecs-1];
    int                     vec_count;
    logic                   vec_loaded;
    logic [`GHIST_SIZE-1:0] model_hist;
    int                     model_pos;
    logic [31:0]            rng;

    branch_predictor_top branch_predictor_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        vec_loaded = 1'b0;
        wait (vec_loaded);
        #(longint'(vec_count + rand_count + 100) * clk_period);
        $display("timeout: the test sequence did not finish in time");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------------------
    // reference model of the history and its folds
    // ------------------------------------------------------------------------
    function automatic logic [7:0] fold_at(int p, int len, int width);
        logic [7:0] f;
        f = '0;
        for (int k = 0; k < len; k++) begin
            f[k % width] = f[k % width] ^ model_hist[(p - 1 - k) & (`GHIST_SIZE - 1)];
        end
        return f;
    endfunction

    function automatic fold_hist_t folds_at(int p);
        fold_hist_t f;
        int         len;
        for (int b = 0; b < `TAGE_BANK; b++) begin
            len = int'(hist_lengths[b*16 +: 16]);
            f.fold_idx[b]  = `TAGE_SET_WIDTH'(fold_at(p, len, `TAGE_SET_WIDTH));
            f.fold_tag1[b] = `TAGE_TAG_COMPRESS1'(fold_at(p, len, `TAGE_TAG_COMPRESS1));
            f.fold_tag2[b] = `TAGE_TAG_COMPRESS2'(fold_at(p, len, `TAGE_TAG_COMPRESS2));
        end
        return f;
    endfunction

    // only the last bit of a block carries taken
    task automatic push_model(int p, int cond, logic tk);
        for (int j = 0; j < cond; j++) begin
            model_hist[(p + j) & (`GHIST_SIZE - 1)] = (j == cond - 1) ? tk : 1'b0;
        end
        model_pos = (p + cond) & (`GHIST_SIZE - 1);
    endtask

    function automatic redirect_info_t make_snapshot(int back);
        redirect_info_t ri;
        ri.ghist_idx    = `GHIST_WIDTH'((model_pos - back) & (`GHIST_SIZE - 1));
        ri.tage_history = folds_at(int'(ri.ghist_idx));
        return ri;
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(logic [63:0] got, logic [63:0] exp, string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic compare_history(string what);
        fold_hist_t exp;
        exp = folds_at(model_pos);
        check_value(64'(history.ghist_idx), 64'(model_pos), {what, " ghist_idx"});
        for (int b = 0; b < `TAGE_BANK; b++) begin
            check_value(64'(history.tage_history.fold_idx[b]), 64'(exp.fold_idx[b]),
                        $sformatf("%s fold_idx[%0d]", what, b));
            check_value(64'(history.tage_history.fold_tag1[b]), 64'(exp.fold_tag1[b]),
                        $sformatf("%s fold_tag1[%0d]", what, b));
            check_value(64'(history.tage_history.fold_tag2[b]), 64'(exp.fold_tag2[b]),
                        $sformatf("%s fold_tag2[%0d]", what, b));
        end
    endtask

    // ------------------------------------------------------------------------
    // operations, each driven 1 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_inputs();
        result        = '0;
        squash        = 1'b0;
        squash_info   = '0;
        req_valid     = 1'b0;
        credit_return = 1'b0;
    endtask

    task automatic advance_history(int cond, logic tk);
        result.en       = 1'b1;
        result.cond_num = 2'(cond);
        result.taken    = tk;
        step();
        clear_inputs();
        push_model(model_pos, cond, tk);
        compare_history("advance");
    endtask

    task automatic redirect_history(int cond, logic tk, int back);
        redirect_info_t ri;
        ri                   = make_snapshot(back);
        result.en            = 1'b1;     // redirect must win over the advance
        result.s2_redirect   = 1'b1;
        result.cond_num      = 2'(cond);
        result.taken         = tk;
        result.redirect_info = ri;
        step();
        clear_inputs();
        push_model(int'(ri.ghist_idx), cond, tk);
        compare_history("redirect");
    endtask

    task automatic squash_history(int cond, logic tk, int back, logic [31:0] aux,
                                  logic [31:0] pc, logic with_redirect);
        redirect_info_t ri;
        ri                        = make_snapshot(back);
        squash                    = 1'b1;
        squash_info.cond_num      = 2'(cond);
        squash_info.taken         = tk;
        squash_info.redirect_info = ri;
        squash_info.pc            = pc;
        squash_info.train_bank    = aux[2:1];
        squash_info.train_taken   = aux[0];
        if (with_redirect) begin
            result.en            = 1'b1;
            result.s2_redirect   = 1'b1;
            result.cond_num      = 2'd1;
            result.taken         = 1'b1;
            result.redirect_info = make_snapshot(4);
        end
        step();
        clear_inputs();
        push_model(int'(ri.ghist_idx), cond, tk);
        compare_history("squash");
    endtask

    task automatic lookup_pc(logic [31:0] pc, logic exp_taken, logic [31:0] exp_provider);
        check_value(64'(req_ready), 64'd1, "req_ready before lookup");
        req_valid = 1'b1;
        req_pc    = pc;
        step();
        req_valid = 1'b0;
        check_value(64'(pred_valid), 64'd0, "pred_valid one cycle after request");
        step();
        check_value(64'(pred_valid), 64'd1, "pred_valid two cycles after request");
        check_value(64'(pred.pc), 64'(pc), "pred.pc");
        check_value(64'(pred.taken), 64'(exp_taken), "pred.taken");
        check_value(64'(pred.provider), 64'(exp_provider[2:0]), "pred.provider");
        check_value(64'(pred.ghist_idx), 64'(model_pos), "pred.ghist_idx");
    endtask

    // request held while out of credits, nothing may come out
    task automatic hold_blocked_request(logic [31:0] pc);
        check_value(64'(req_ready), 64'd0, "req_ready with no credits");
        req_valid = 1'b1;
        req_pc    = pc;
        repeat (4) begin
            step();
            check_value(64'(req_ready), 64'd0, "req_ready while blocked");
            check_value(64'(pred_valid), 64'd0, "pred_valid while blocked");
        end
        req_valid = 1'b0;
    endtask

    task automatic return_credits(int pulses, logic exp_ready);
        credit_return = 1'b1;
        repeat (pulses) step();
        credit_return = 1'b0;
        check_value(64'(req_ready), 64'(exp_ready), "req_ready after credit return");
    endtask

    initial begin
        int          base;
        logic [31:0] op;
        logic [31:0] cond;
        logic [31:0] tk;
        logic [31:0] back;
        logic [31:0] exp_idx;
        logic [31:0] aux;
        logic [31:0] pc;

        rst        = 1'b1;
        req_pc     = '0;
        clear_inputs();
        model_hist = '0;
        model_pos  = 0;
        rng        = 32'd41;

        $readmemh("tb/bp_vectors.txt", vec_mem);
        vec_count = 0;
        while (vec_count < max_vecs && vec_mem[vec_count*vec_fields] != 0) begin
            vec_count++;
        end
        vec_loaded = 1'b1;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_history("after reset");
        check_value(64'(pred_valid), 64'd0, "pred_valid after reset");
        check_value(64'(req_ready), 64'd1, "req_ready after reset");

        for (int i = 0; i < vec_count; i++) begin
            base    = i * vec_fields;
            op      = vec_mem[base];
            cond    = vec_mem[base + 1];
            tk      = vec_mem[base + 2];
            back    = vec_mem[base + 3];
            exp_idx = vec_mem[base + 4];
            aux     = vec_mem[base + 5];
            pc      = vec_mem[base + 6];
            case (op)
                1: advance_history(int'(cond), tk[0]);
                2: redirect_history(int'(cond), tk[0], int'(back));
                3: squash_history(int'(cond), tk[0], int'(back), aux, pc, 1'b0);
                4: lookup_pc(pc, tk[0], aux);
                5: return_credits(int'(cond), tk[0]);
                6: squash_history(int'(cond), tk[0], int'(back), aux, pc, 1'b1);
                7: hold_blocked_request(pc);
                default: begin
                    $display("vector %0d has an unknown opcode %0h", i, op);
                    $display(">>> FAIL");
                    $fatal(1, "bad vector file");
                end
            endcase
            if (op == 1 || op == 2 || op == 3 || op == 6) begin
                check_value(64'(history.ghist_idx), 64'(exp_idx),
                            $sformatf("vector %0d ghist_idx", i));
            end
        end

        // long random run wraps the buffer many times
        for (int i = 0; i < rand_count; i++) begin
            rng = xorshift(rng);
            advance_history(int'(rng % 3), rng[7]);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule
